/* reg_client.f */
rtl/reg_client_pkg.sv
rtl/client_pipe_if.sv
rtl/client_framer.sv
rtl/reg_exec.sv
rtl/reply_mux.sv
rtl/reg_client_top.sv
testbench/tb_clock.sv
testbench/packet_driver.sv
testbench/reg_client_tb.sv

/* rtl/client_framer.sv */
// ########################################
// Input stage, one register after idata
// len_c must be valid on every byte with raw_s high
// ########################################
`timescale 1ns/10ps

module client_framer (
	input  logic clk,
	input  logic arst_n,
	input  logic raw_s,  // Payload strobe
	input  logic [reg_client_pkg::byte_w-1:0] idata,
	input  logic [reg_client_pkg::len_w-1:0] len_c,  // Count-down length
	frame_if.src frame
);

	logic [reg_client_pkg::len_w-1:0] remain;  // Payload bytes left, this one included
	logic last_q;  // Previous byte closed its packet
	logic first;  // This byte opens a packet
	logic [1:0] pos_n;  // Word position of this byte

	assign remain = len_c - reg_client_pkg::len_bias;

	// New packet on a rising strobe, or right after a last byte
	// The second case covers packets sent with no gap
	assign first = raw_s && (!frame.strobe || last_q);

	// Position wraps every word, restarts with the packet
	assign pos_n = first ? 2'd0 : frame.byte_pos + 2'd1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frame.strobe <= 1'b0;
			frame.byte_pos <= 2'd0;
			frame.in_nonce <= 1'b0;
			frame.exec_ok <= 1'b0;
			last_q <= 1'b0;
		end else begin
			frame.strobe <= raw_s;
			// Only one byte left means this is the last one
			last_q <= raw_s && (remain == {{(reg_client_pkg::len_w-1){1'b0}}, 1'b1});
			if (raw_s) begin
				frame.byte_pos <= pos_n;
				if (first) begin
					frame.in_nonce <= 1'b1;  // Word 0 is the nonce
				end else if (pos_n == 2'd0) begin
					frame.in_nonce <= 1'b0;  // Nonce ends at the first word boundary
				end
				// Fit check once per word, held for bytes 1 to 3
				if (pos_n == 2'd0) begin
					frame.exec_ok <= (remain >= reg_client_pkg::word_len);
				end
			end else begin
				// Idle between packets
				frame.byte_pos <= 2'd0;
				frame.in_nonce <= 1'b0;
				frame.exec_ok <= 1'b0;
			end
		end
	end

	// Byte is payload only, qualified by strobe downstream
	always_ff @(posedge clk) begin
		frame.byte_val <= idata;
	end

endmodule

/* rtl/client_pipe_if.sv */
// ########################################
// Stage buses of the client pipeline
// One byte per cycle while strobe is high, no back-pressure
// ########################################
`timescale 1ns/10ps

// Framer to exec
interface frame_if;
	logic [reg_client_pkg::byte_w-1:0] byte_val;  // Registered input byte
	logic strobe;  // Byte belongs to the payload
	logic [1:0] byte_pos;  // Position within the 4-byte word
	logic in_nonce;  // Word 0 of the packet
	logic exec_ok;  // Whole word lies inside the payload
	modport src (output byte_val, strobe, byte_pos, in_nonce, exec_ok);
	modport dst (input byte_val, strobe, byte_pos, in_nonce, exec_ok);
endinterface

// Exec to output mux
interface reply_if;
	logic [reg_client_pkg::byte_w-1:0] byte_val;  // Byte one stage later
	logic strobe;
	logic [1:0] byte_pos;
	logic subst;  // Data byte of an executable read
	logic [reg_client_pkg::reg_dw-1:0] rd_word;  // Register contents or zero
	modport src (output byte_val, strobe, byte_pos, subst, rd_word);
	modport dst (input byte_val, strobe, byte_pos, subst, rd_word);
endinterface

/* rtl/reg_client_pkg.sv */
// ########################################
// Widths, op codes and register count of the register client
// len_c carries the remaining payload count plus len_bias
// ########################################
package reg_client_pkg;

	// Stream widths
	localparam int byte_w = 8;  // One stream byte
	localparam int len_w = 11;  // Width of the count-down length len_c

	// len_c sits this far above the number of bytes still to come
	localparam logic [len_w-1:0] len_bias = 11'd8;

	// Payload is built from 4-byte words
	localparam int word_bytes = 4;
	// Same value at the width of len_c, for the fit check
	localparam logic [len_w-1:0] word_len = len_w'(word_bytes);

	// Register file geometry
	localparam int reg_count = 16;  // Number of registers
	localparam int reg_aw = 4;  // Index width, covers reg_count
	localparam int reg_dw = 16;  // Two data bytes, high byte first

	// Command op byte, first byte of each command word
	localparam logic [byte_w-1:0] op_read = 8'h01;  // Data bytes replaced by register
	localparam logic [byte_w-1:0] op_write = 8'h02;  // Data bytes echoed, register written
	// Any other op is echoed with no effect

	// Reply latency from idata to odata in clock cycles
	// One register each in framer, exec and mux
	localparam int pipe_lat = 3;

endpackage

/* rtl/reg_client_top.sv */
// ########################################
// Register client, one reply byte on odata per input byte
// Fixed latency of three cycles, no handshake
// ########################################
`timescale 1ns/10ps

module reg_client_top (
	input  logic clk,
	input  logic arst_n,
	input  logic raw_s,  // Payload strobe from the host side
	input  logic [reg_client_pkg::byte_w-1:0] idata,
	input  logic [reg_client_pkg::len_w-1:0] len_c,
	output logic [reg_client_pkg::byte_w-1:0] odata  // Reply byte
);

	// Stage buses
	frame_if frame_bus ();  // Framer to exec
	reply_if reply_bus ();  // Exec to mux

	// Stage 1, word position and fit check
	client_framer client_framer_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.raw_s  (raw_s),
		.idata  (idata),
		.len_c  (len_c),
		.frame  (frame_bus)
	);

	// Stage 2, commands and register file
	reg_exec reg_exec_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.frame  (frame_bus),
		.reply  (reply_bus)
	);

	// Stage 3, read data substitution
	reply_mux reply_mux_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.reply  (reply_bus),
		.odata  (odata)
	);

endmodule

/* rtl/reg_exec.sv */
// ########################################
// Command stage with the 16 x 16 register file
// Writes land as byte 3 leaves, reads see them from the next word on
// ########################################
`timescale 1ns/10ps

module reg_exec (
	input  logic clk,
	input  logic arst_n,
	frame_if.dst frame,
	reply_if.src reply
);

	logic [reg_client_pkg::byte_w-1:0] op_q;  // Op byte of the current word
	logic [reg_client_pkg::byte_w-1:0] addr_q;  // Address byte of the current word
	logic [reg_client_pkg::byte_w-1:0] hi_q;  // High data byte of a write
	logic [reg_client_pkg::reg_dw-1:0] regs [reg_client_pkg::reg_count];
	logic [reg_client_pkg::reg_aw-1:0] idx;
	logic in_range;
	logic cmd_ok;
	logic data_pos;
	logic rd_hit;
	logic wr_hit;

	// Low address bits index the file
	assign idx = addr_q[reg_client_pkg::reg_aw-1:0];
	// Any upper address bit set means out of range
	assign in_range = (addr_q[reg_client_pkg::byte_w-1:reg_client_pkg::reg_aw] == '0);

	// Command word that fits in the payload
	assign cmd_ok = frame.strobe && !frame.in_nonce && frame.exec_ok;

	// Positions 2 and 3 carry the data value
	assign data_pos = frame.byte_pos[1];

	// Read replaces both data bytes, also for out of range addresses
	assign rd_hit = cmd_ok && data_pos && (op_q == reg_client_pkg::op_read);

	// Write commits on the low data byte
	assign wr_hit = cmd_ok && (frame.byte_pos == 2'd3)
		&& (op_q == reg_client_pkg::op_write) && in_range;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reply.strobe <= 1'b0;
			reply.byte_pos <= 2'd0;
			reply.subst <= 1'b0;
			op_q <= '0;
			addr_q <= '0;
			// Every register reads 0 after reset
			for (int i = 0; i < reg_client_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else begin
			reply.strobe <= frame.strobe;
			reply.byte_pos <= frame.strobe ? frame.byte_pos : 2'd0;
			reply.subst <= rd_hit;
			// Op and address latch on bytes 0 and 1
			if (frame.strobe && (frame.byte_pos == 2'd0)) begin
				op_q <= frame.byte_val;
			end
			if (frame.strobe && (frame.byte_pos == 2'd1)) begin
				addr_q <= frame.byte_val;
			end
			if (wr_hit) begin
				regs[idx] <= {hi_q, frame.byte_val};  // High byte came first
			end
		end
	end

	// Data path, qualified by strobe and subst
	always_ff @(posedge clk) begin
		reply.byte_val <= frame.byte_val;
		// Lookup runs every cycle, mux picks it up on data bytes
		reply.rd_word <= in_range ? regs[idx] : '0;
		if (frame.strobe && (frame.byte_pos == 2'd2)) begin
			hi_q <= frame.byte_val;  // Held until byte 3
		end
	end

endmodule

/* rtl/reply_mux.sv */
// ########################################
// Output stage, odata is 0 while no reply byte is present
// ########################################
`timescale 1ns/10ps

module reply_mux (
	input  logic clk,
	input  logic arst_n,
	reply_if.dst reply,
	output logic [reg_client_pkg::byte_w-1:0] odata
);

	logic [reg_client_pkg::byte_w-1:0] sel;  // Reply byte before the register

	// Echo by default, read data on substituted bytes
	always_comb begin
		sel = reply.byte_val;
		if (reply.subst) begin
			if (reply.byte_pos == 2'd2) begin
				sel = reply.rd_word[reg_client_pkg::reg_dw-1:reg_client_pkg::byte_w];  // High half
			end else if (reply.byte_pos == 2'd3) begin
				sel = reply.rd_word[reg_client_pkg::byte_w-1:0];  // Low half
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			odata <= '0;
		end else begin
			odata <= reply.strobe ? sel : '0;  // Zero between packets
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run from the project root, the golden file path is relative to it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps --top-module reg_client_tb \
	-f reg_client.f -o reg_client_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/reg_client_sim > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log && exit 0
echo "No result line found in sim.log"
exit 1

/* testbench/packet_driver.sv */
// ########################################
// Drives packets from the golden file on the falling edge
// Records 1TTLL packet, 0IIEE byte, 200GG gap, F0000 end
// ########################################
`timescale 1ns/10ps

module packet_driver (
	input  logic clk,
	input  logic start,  // High once reset is released
	output logic raw_s,
	output logic [reg_client_pkg::byte_w-1:0] idata,
	output logic [reg_client_pkg::len_w-1:0] len_c,
	output logic exp_valid,  // Driven byte carries an expected reply
	output logic [reg_client_pkg::byte_w-1:0] exp_byte,
	output logic [7:0] test_id,
	output int sent_count,  // Payload bytes driven so far
	output int budget,  // Bytes plus gap cycles in the file
	output logic file_ok,  // End record found, all kinds known
	output logic done
);

	localparam int depth = 128;

	logic [19:0] golden [depth];
	logic [3:0] kind;  // Record type digit
	logic [7:0] pkt_id;  // Test id of the packet being sent
	int ptr;
	int remain;  // Payload bytes left, this one included
	logic finished;

	// Bus between packets
	task automatic drive_idle();
		raw_s = 1'b0;
		idata = '0;
		len_c = '0;
		exp_valid = 1'b0;
		exp_byte = '0;  // odata must be 0 here
	endtask

	initial begin
		drive_idle();
		test_id = '0;
		pkt_id = '0;
		remain = 0;
		sent_count = 0;
		budget = 0;
		file_ok = 1'b0;
		done = 1'b0;
		$readmemh("testbench/reg_client_golden.hex", golden);
		// Size the run up front, the watchdog needs it
		ptr = 0;
		finished = 1'b0;
		while (!finished && ptr < depth) begin
			kind = golden[ptr][19:16];
			if (kind == 4'h0) begin
				budget += 1;  // One cycle per byte
			end else if (kind == 4'h2) begin
				budget += int'(golden[ptr][7:0]);
			end else if (kind == 4'hF) begin
				file_ok = 1'b1;
				finished = 1'b1;
			end else if (kind != 4'h1) begin
				finished = 1'b1;  // Unknown kind, file_ok stays low
			end
			ptr++;
		end

		wait (start);
		ptr = 0;
		finished = !file_ok;
		while (!finished && ptr < depth) begin
			kind = golden[ptr][19:16];
			if (kind == 4'h1) begin
				pkt_id = golden[ptr][15:8];  // Shown from the first byte on
				remain = int'(golden[ptr][7:0]);
			end else if (kind == 4'h0) begin
				@(negedge clk);
				raw_s = 1'b1;
				idata = golden[ptr][15:8];
				// Count-down length, bytes left plus the bias
				len_c = reg_client_pkg::len_bias + remain[reg_client_pkg::len_w-1:0];
				exp_valid = 1'b1;
				exp_byte = golden[ptr][7:0];
				test_id = pkt_id;
				sent_count++;
				remain--;
			end else if (kind == 4'h2) begin
				repeat (int'(golden[ptr][7:0])) begin
					@(negedge clk);
					drive_idle();
				end
			end else begin
				finished = 1'b1;  // End record
			end
			ptr++;
		end
		@(negedge clk);
		drive_idle();
		done = 1'b1;
	end

endmodule

/* testbench/reg_client_golden.hex */
// Kind digit then two bytes: 1 = packet (test id, payload length), 0 = byte (input, expected
// odata), 2 = idle gap (00, cycles), F = end of stimulus
// Test 5: registers read zero right after reset
1_05_0C
0_11_11
0_22_22
0_33_33
0_44_44
0_01_01
0_00_00
0_FF_00
0_FF_00
0_01_01
0_0F_0F
0_AA_00
0_55_00
2_00_03
// Test 1: nonce and an unknown op are echoed
1_01_08
0_DE_DE
0_AD_AD
0_BE_BE
0_EF_EF
0_7F_7F
0_03_03
0_12_12
0_34_34
2_00_02
// Test 2: write reg 3, read it back in the same packet
1_02_0C
0_00_00
0_00_00
0_00_00
0_01_01
0_02_02
0_03_03
0_BE_BE
0_EF_EF
0_01_01
0_03_03
0_00_BE
0_00_EF
2_00_01
// Test 3: address 0x13 reads zero and its write leaves reg 3 alone
1_03_10
0_A5_A5
0_A5_A5
0_A5_A5
0_A5_A5
0_02_02
0_13_13
0_77_77
0_88_88
0_01_01
0_13_13
0_66_00
0_66_00
0_01_01
0_03_03
0_00_BE
0_00_EF
2_00_02
// Test 4: full write to reg 5, then a cut write word
1_04_0B
0_4C_4C
0_4D_4D
0_4E_4E
0_4F_4F
0_02_02
0_05_05
0_CA_CA
0_FE_FE
0_02_02
0_05_05
0_11_11
// Next packet with no gap, reg 5 kept, cut read echoed
1_04_0B
0_50_50
0_51_51
0_52_52
0_53_53
0_01_01
0_05_05
0_00_CA
0_00_FE
0_01_01
0_05_05
0_99_99
2_00_04
// Test 6: zero gap packets, reg 3 read from a later packet
1_06_08
0_01_01
0_02_02
0_03_03
0_04_04
0_01_01
0_03_03
0_00_BE
0_00_EF
1_06_08
0_05_05
0_06_06
0_07_07
0_08_08
0_01_01
0_05_05
0_00_CA
0_00_FE
2_00_02
F_00_00

/* testbench/reg_client_tb.sv */
// ########################################
// Testbench for reg_client_top, stimulus and replies come from the golden file
// Run from the project root so the file path resolves
// ########################################
`timescale 1ns/10ps

module reg_client_tb;

	localparam int reset_cycles = 5;

	logic clk;
	logic arst_n;
	logic raw_s;
	logic [reg_client_pkg::byte_w-1:0] idata;
	logic [reg_client_pkg::len_w-1:0] len_c;
	logic [reg_client_pkg::byte_w-1:0] odata;
	logic start;  // Stimulus may begin
	logic exp_valid;
	logic [reg_client_pkg::byte_w-1:0] exp_byte;
	logic [7:0] test_id;
	int sent_count;
	int budget;
	logic file_ok;
	logic done;
	logic [16:0] expect_q [$];  // {payload flag, test id, expected odata}
	int checked;  // Payload bytes compared

	tb_clock tb_clock_inst (
		.clk (clk)
	);

	packet_driver packet_driver_inst (
		.clk        (clk),
		.start      (start),
		.raw_s      (raw_s),
		.idata      (idata),
		.len_c      (len_c),
		.exp_valid  (exp_valid),
		.exp_byte   (exp_byte),
		.test_id    (test_id),
		.sent_count (sent_count),
		.budget     (budget),
		.file_ok    (file_ok),
		.done       (done)
	);

	reg_client_top reg_client_top_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.raw_s  (raw_s),
		.idata  (idata),
		.len_c  (len_c),
		.odata  (odata)
	);

	function automatic string test_name(input logic [7:0] id);
		case (id)
			8'd1: return "echo";
			8'd2: return "write_read";
			8'd3: return "out_of_range";
			8'd4: return "truncated";
			8'd5: return "reset_zero";
			8'd6: return "back_to_back";
			default: return "idle";  // Before the first packet
		endcase
	endfunction

	// Reason first, then the verdict, then stop
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("Mismatch in %s: expected %0h, actual %0h",
				name, expected, actual));
		end
	endtask

	// What the DUT takes in on each rising edge
	always @(posedge clk) begin
		if (start) begin
			expect_q.push_back({exp_valid, test_id, exp_byte});
		end
	end

	// Reply to the byte taken pipe_lat edges back, ready for the next edge
	always @(negedge clk) begin
		logic [16:0] entry;
		if (expect_q.size() >= reg_client_pkg::pipe_lat) begin
			entry = expect_q.pop_front();
			check_value(test_name(entry[15:8]), 32'(entry[7:0]), 32'(odata));
			if (entry[16]) begin
				checked++;
			end
		end
	end

	initial begin
		arst_n = 1'b0;
		start = 1'b0;
		checked = 0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;  // Release away from the rising edge
		start = 1'b1;
		if (!file_ok) begin
			fail_run("The golden file has an unknown record or no end record");
		end
		wait (done);
		// Drain the last replies
		repeat (reg_client_pkg::pipe_lat + 1) @(negedge clk);
		check_value("byte count", 32'(sent_count), 32'(checked));
		$display("Result: PASSED");
		$finish;
	end

	// Twice the bytes and gaps of the golden file
	initial begin
		wait (start);
		repeat (2 * budget) @(posedge clk);
		fail_run($sformatf("Timeout: stimulus did not finish within %0d cycles", 2 * budget));
	end

endmodule

/* testbench/tb_clock.sv */
// ########################################
// Free-running clock, 100 ns period, starts low
// ########################################
`timescale 1ns/10ps

module tb_clock (
	output logic clk
);

	localparam int half_period = 50;  // ns

	initial begin
		clk = 1'b0;
		forever begin
			#half_period clk = ~clk;  // Toggle twice per period
		end
	end

endmodule
